// File: Makefile
TOP       ?= control_plane_tb
LOG       ?= sim.log
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/control_plane_tb.sv
`timescale 1ns/100ps
`include "cgra_defines.svh"

module control_plane_tb;
  import ctrl_pkg::*;
  import loader_pkg::*;

  localparam int TIMEOUT    = 2000;
  localparam int POLL_LIMIT = 300;

  logic                         ap_clk;
  logic                         areset;
  logic [`CSR_ADDR_W-1:0]       awaddr;
  logic                         awvalid;
  logic                         awready;
  logic [`CSR_DATA_W-1:0]       wdata;
  logic [`CSR_DATA_W/8-1:0]     wstrb;
  logic                         wvalid;
  logic                         wready;
  logic [1:0]                   bresp;
  logic                         bvalid;
  logic                         bready;
  logic [`CSR_ADDR_W-1:0]       araddr;
  logic                         arvalid;
  logic                         arready;
  logic [`CSR_DATA_W-1:0]       rdata;
  logic [1:0]                   rresp;
  logic                         rvalid;
  logic                         rready;
  logic                         interrupt;
  logic                         m_axi_arvalid;
  logic                         m_axi_arready;
  logic [`HBM_ADDR_W-1:0]       m_axi_araddr;
  logic [7:0]                   m_axi_arlen;
  logic                         m_axi_rvalid;
  logic                         m_axi_rready;
  logic [`PHIT_W-1:0]           m_axi_rdata;
  logic                         m_axi_rlast;
  pc_ctl_t [`NUM_COL-1:0]       pc_ctl;
  logic [`NUM_COL*`INSTR_W-1:0] instr;
  logic                         gaps_en;
  logic                         stalled;

  // expected table contents rebuilt after each load
  logic [`INSTR_W-1:0]    shadow [`TBL_DEPTH][`NUM_COL];
  logic [`HBM_ADDR_W-1:0] load_ptr;
  int                     burst_cnt;
  logic                   clear_bursts;
  // host view of the enables
  logic                   gie_tb;
  logic                   ier_tb;

  control_plane DUT (.*);

  tb_hbm_model hbm (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .gaps_en (gaps_en),
    .arvalid (m_axi_arvalid),
    .arready (m_axi_arready),
    .araddr  (m_axi_araddr),
    .arlen   (m_axi_arlen),
    .rvalid  (m_axi_rvalid),
    .rready  (m_axi_rready),
    .rdata   (m_axi_rdata),
    .rlast   (m_axi_rlast),
    .stalled (stalled)
  );

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  // bursts seen since the last start
  always @(posedge ap_clk) begin
    if (clear_bursts) burst_cnt <= 0;
    else if (m_axi_arvalid && m_axi_arready) burst_cnt <= burst_cnt + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    assert (got === exp)
      else abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  // responses hold until taken and are always OKAY
  assert property (@(posedge ap_clk) disable iff (areset) bvalid && !bready |=> bvalid)
    else abort_run("write response dropped before bready");
  assert property (@(posedge ap_clk) disable iff (areset)
                   rvalid && !rready |=> rvalid && $stable(rdata))
    else abort_run("read response changed before rready");
  assert property (@(posedge ap_clk) disable iff (areset)
                   (bvalid || rvalid) |-> (bresp == 2'b00 && rresp == 2'b00))
    else abort_run($sformatf("mismatch bresp/rresp: got 0x%h/0x%h expected 0x0/0x0",
                             $sampled(bresp), $sampled(rresp)));
  // read master address channel
  assert property (@(posedge ap_clk) disable iff (areset)
                   m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
    else abort_run("arvalid or araddr changed before arready");
  assert property (@(posedge ap_clk) disable iff (areset)
                   m_axi_arvalid && m_axi_arready |-> m_axi_arlen == 8'h07)
    else abort_run($sformatf("mismatch m_axi_arlen: got 0x%h expected 0x07",
                             $sampled(m_axi_arlen)));
  assert property (@(posedge ap_clk) disable iff (areset)
                   m_axi_arvalid && m_axi_arready
                   |-> m_axi_araddr == load_ptr + 64'(64 * burst_cnt))
    else abort_run($sformatf("mismatch m_axi_araddr: got 0x%h expected 0x%h",
                             $sampled(m_axi_araddr),
                             $sampled(load_ptr) + 64'(64 * $sampled(burst_cnt))));
  assert property (@(posedge ap_clk) disable iff (areset) interrupt |-> gie_tb && ier_tb)
    else abort_run("interrupt raised without both enables set");
  assert property (@(posedge ap_clk) !stalled)
    else abort_run("memory model gave up waiting for rready");

  function automatic logic [`INSTR_W-1:0] word_at(input logic [`HBM_ADDR_W-1:0] a);
    return a[31:0] ^ 32'hC0DE_0000;
  endfunction

  // aw and w together, then the response held hold_b cycles
  task automatic write_reg(input logic [`CSR_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold_b);
    int t;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    t = 0;
    while (!(awready && wready)) begin
      @(negedge ap_clk);
      t++;
      if (t > TIMEOUT) abort_run("write address/data handshake timed out");
    end
    @(negedge ap_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (hold_b) @(negedge ap_clk);
    bready = 1'b1;
    t = 0;
    while (!bvalid) begin
      @(negedge ap_clk);
      t++;
      if (t > TIMEOUT) abort_run("write response never arrived");
    end
    @(negedge ap_clk);
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [`CSR_ADDR_W-1:0] addr, input int hold_r,
                          output logic [31:0] data);
    int t;
    araddr  = addr;
    arvalid = 1'b1;
    t = 0;
    while (!arready) begin
      @(negedge ap_clk);
      t++;
      if (t > TIMEOUT) abort_run("read address handshake timed out");
    end
    @(negedge ap_clk);
    arvalid = 1'b0;
    repeat (hold_r) @(negedge ap_clk);
    rready = 1'b1;
    t = 0;
    while (!rvalid) begin
      @(negedge ap_clk);
      t++;
      if (t > TIMEOUT) abort_run("read response never arrived");
    end
    data = rdata;
    @(negedge ap_clk);
    rready = 1'b0;
  endtask

  // program, read back, start, poll ctrl for done
  task automatic run_load(input logic [63:0] ptr, input int rows, input logic gie,
                          input logic ier);
    logic [31:0] val;
    int          t;
    write_reg(ADDR_GIER, {31'd0, gie}, 4'hF, 1);
    gie_tb = gie;
    write_reg(ADDR_IER, {31'd0, ier}, 4'hF, 0);
    ier_tb = ier;
    write_reg(ADDR_PTR_LO, ptr[31:0], 4'hF, 2);
    write_reg(ADDR_PTR_HI, ptr[63:32], 4'hF, 0);
    write_reg(ADDR_ROWS, 32'(rows), 4'hF, 3);
    read_reg(ADDR_PTR_LO, 1, val);
    expect_value("ptr_lo", 64'(val), 64'(ptr[31:0]));
    read_reg(ADDR_PTR_HI, 0, val);
    expect_value("ptr_hi", 64'(val), 64'(ptr[63:32]));
    read_reg(ADDR_ROWS, 2, val);
    expect_value("rows", 64'(val), 64'(rows));
    read_reg(ADDR_IER, 0, val);
    expect_value("ier", 64'(val), 64'(ier));
    load_ptr     = ptr;
    clear_bursts = 1'b1;
    @(negedge ap_clk);
    clear_bursts = 1'b0;
    write_reg(ADDR_CTRL, 32'h1, 4'hF, 0);
    read_reg(ADDR_CTRL, 0, val);
    expect_value("ctrl idle while loading", 64'(val[2]), 64'd0);
    t = 0;
    while (!val[1]) begin
      read_reg(ADDR_CTRL, 0, val);
      t++;
      if (t > POLL_LIMIT) abort_run("load never finished, done bit not seen");
    end
    // ready, idle, done all up on the read that finds done
    expect_value("ctrl at done", 64'(val), 64'h0E);
    read_reg(ADDR_CTRL, 1, val);
    expect_value("ctrl after clearing read", 64'(val), 64'h04);
    expect_value("burst count", 64'(burst_cnt), 64'(rows / 4));
    read_reg(ADDR_ISR, 0, val);
    expect_value("isr", 64'(val), 64'(ier));
    expect_value("interrupt", 64'(interrupt), 64'(gie & ier));
    read_reg(ADDR_BUSY, 0, val);
    assert (val != 0)
      else abort_run("busy counter read zero after a load");
    if (ier) begin
      // write 1 toggles the done bit back off
      write_reg(ADDR_ISR, 32'h1, 4'hF, 0);
      expect_value("interrupt after isr write", 64'(interrupt), 64'd0);
      read_reg(ADDR_ISR, 0, val);
      expect_value("isr after write", 64'(val), 64'd0);
    end
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < `NUM_COL; c++) begin
        shadow[r][c] = word_at(ptr + 64'(4 * (`NUM_COL * r + c)));
      end
    end
  endtask

  task automatic check_cols(input int base, input int step);
    int r;
    for (int c = 0; c < `NUM_COL; c++) begin
      r = (base + c + step) % `TBL_DEPTH;
      expect_value($sformatf("instr[%0d]", c), 64'(instr[c*`INSTR_W +: `INSTR_W]),
                   64'(shadow[r][c]));
    end
  endtask

  // column c loaded with base+c, stepped once, then held with clken low
  task automatic sweep_pcs();
    for (int base = 0; base < `TBL_DEPTH; base++) begin
      for (int c = 0; c < `NUM_COL; c++) begin
        // incr set too so load must win
        pc_ctl[c] = '{clken: 1'b1, load: 1'b1, incr: 1'b1, value: `PC_W'(base + c)};
      end
      @(negedge ap_clk);
      pc_ctl = '0;
      @(negedge ap_clk);
      check_cols(base, 0);
      for (int c = 0; c < `NUM_COL; c++) begin
        pc_ctl[c] = '{clken: 1'b1, load: 1'b0, incr: 1'b1, value: '0};
      end
      @(negedge ap_clk);
      for (int c = 0; c < `NUM_COL; c++) begin
        pc_ctl[c] = '{clken: 1'b0, load: 1'b1, incr: 1'b1, value: '0};
      end
      @(negedge ap_clk);
      check_cols(base, 1);
      repeat (2) @(negedge ap_clk);
      check_cols(base, 1);
      pc_ctl = '0;
    end
  endtask

  initial begin
    logic [31:0] val;
    areset       = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    pc_ctl       = '0;
    gaps_en      = 1'b0;
    clear_bursts = 1'b0;
    gie_tb       = 1'b0;
    ier_tb       = 1'b0;
    load_ptr     = '0;
    repeat (5) @(negedge ap_clk);
    // reset state, sampled while the table is still unwritten
    expect_value("awready", 64'(awready), 64'd0);
    expect_value("wready", 64'(wready), 64'd0);
    expect_value("bvalid", 64'(bvalid), 64'd0);
    expect_value("arready", 64'(arready), 64'd0);
    expect_value("rvalid", 64'(rvalid), 64'd0);
    expect_value("m_axi_arvalid", 64'(m_axi_arvalid), 64'd0);
    expect_value("m_axi_rready", 64'(m_axi_rready), 64'd0);
    expect_value("interrupt", 64'(interrupt), 64'd0);
    for (int c = 0; c < `NUM_COL; c++) begin
      expect_value($sformatf("instr[%0d]", c), 64'(instr[c*`INSTR_W +: `INSTR_W]), 64'd0);
    end
    areset = 1'b0;
    @(negedge ap_clk);
    read_reg(ADDR_CTRL, 0, val);
    expect_value("ctrl after reset", 64'(val), 64'h04);
    // byte lanes of the pointer
    write_reg(ADDR_PTR_LO, 32'h1122_3344, 4'hF, 3);
    write_reg(ADDR_PTR_LO, 32'hAABB_CCDD, 4'b0110, 0);
    read_reg(ADDR_PTR_LO, 2, val);
    expect_value("ptr_lo strobed", 64'(val), 64'h11BB_CC44);
    // full table with isr but no global enable
    run_load(64'h0000_0001_0000_1000, 16, 1'b0, 1'b1);
    sweep_pcs();
    // half the table under random gaps with the interrupt enabled
    gaps_en = 1'b1;
    run_load(64'h0000_0002_0004_8C40, 8, 1'b1, 1'b1);
    sweep_pcs();
    // done interrupt masked
    run_load(64'h0000_0000_7FF0_0200, 4, 1'b1, 1'b0);
    sweep_pcs();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: dv/tb_hbm_model.sv
`timescale 1ns/100ps
`include "cgra_defines.svh"

module tb_hbm_model (
  input  logic                   ap_clk,
  input  logic                   areset,
  input  logic                   gaps_en,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [`HBM_ADDR_W-1:0] araddr,
  input  logic [7:0]             arlen,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [`PHIT_W-1:0]     rdata,
  output logic                   rlast,
  output logic                   stalled
);

  localparam int RREADY_WAIT = 200;

  int unsigned            lcg_q;
  logic [`HBM_ADDR_W-1:0] addr;
  int                     len;
  int                     wait_cnt;

  // 32-bit lcg, upper half gives the gap
  function automatic int unsigned next_rand();
    lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
    return lcg_q >> 16;
  endfunction

  // idle cycles before arready or rvalid rises
  function automatic int gap();
    if (!gaps_en) return 0;
    return int'(next_rand() % 4);
  endfunction

  // word at byte address a is a xor c0de0000, lower address in the low half
  function automatic logic [`PHIT_W-1:0] phit_at(input logic [`HBM_ADDR_W-1:0] a);
    logic [`HBM_ADDR_W-1:0] hi;
    hi = a + 64'd4;
    return {hi[31:0] ^ 32'hC0DE_0000, a[31:0] ^ 32'hC0DE_0000};
  endfunction

  initial begin
    lcg_q   = 29403;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rlast   = 1'b0;
    stalled = 1'b0;
    forever begin
      @(negedge ap_clk);
      if (!areset && arvalid) begin
        repeat (gap()) @(negedge ap_clk);
        // address taken at the next rising edge
        arready = 1'b1;
        addr    = araddr;
        len     = int'(arlen);
        @(negedge ap_clk);
        arready = 1'b0;
        for (int i = 0; i <= len; i++) begin
          repeat (gap()) @(negedge ap_clk);
          rvalid   = 1'b1;
          rdata    = phit_at(addr + 64'(8 * i));
          rlast    = (i == len);
          wait_cnt = 0;
          while (!rready && !stalled) begin
            @(negedge ap_clk);
            wait_cnt++;
            if (wait_cnt > RREADY_WAIT) stalled = 1'b1;
          end
          @(negedge ap_clk);
          rvalid = 1'b0;
          rlast  = 1'b0;
        end
      end
    end
  end

endmodule

// File: files.f
+incdir+logic
logic/ctrl_pkg.sv
logic/loader_pkg.sv
logic/ctrl_regs.sv
logic/instr_fetch.sv
logic/instr_unpack.sv
logic/instr_table.sv
logic/control_plane.sv
dv/tb_hbm_model.sv
dv/control_plane_tb.sv

// File: logic/cgra_defines.svh
`ifndef CGRA_DEFINES_SVH
`define CGRA_DEFINES_SVH

// array geometry
`define NUM_COL     4
`define INSTR_W     32
// memory beat size and beats per instruction row
`define PHIT_W      64
`define ROW_BEATS   2
// instruction table depth and program counter width
`define TBL_DEPTH   16
`define PC_W        4
// read master
`define HBM_ADDR_W  64
`define BURST_BEATS 8
// host register bus
`define CSR_ADDR_W  6
`define CSR_DATA_W  32

`endif

// File: logic/control_plane.sv
`timescale 1ns/100ps
`include "cgra_defines.svh"

module control_plane (
  input  logic                               ap_clk,
  input  logic                               areset,
  // host register bus
  input  logic [`CSR_ADDR_W-1:0]             awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [`CSR_DATA_W-1:0]             wdata,
  input  logic [`CSR_DATA_W/8-1:0]           wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  logic [`CSR_ADDR_W-1:0]             araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [`CSR_DATA_W-1:0]             rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready,
  output logic                               interrupt,
  // instruction memory read master
  output logic                               m_axi_arvalid,
  input  logic                               m_axi_arready,
  output logic [`HBM_ADDR_W-1:0]             m_axi_araddr,
  output logic [7:0]                         m_axi_arlen,
  input  logic                               m_axi_rvalid,
  output logic                               m_axi_rready,
  input  logic [`PHIT_W-1:0]                 m_axi_rdata,
  input  logic                               m_axi_rlast,
  // array side
  input  loader_pkg::pc_ctl_t [`NUM_COL-1:0] pc_ctl,
  output logic [`NUM_COL*`INSTR_W-1:0]       instr
);
  import ctrl_pkg::*;
  import loader_pkg::*;

  load_cmd_t load_cmd;
  phit_t     beat;
  row_wr_t   row_wr;
  logic      load_done;

  // final row write closes the load
  assign load_done = row_wr.valid & row_wr.last;

  ctrl_regs u_ctrl_regs (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .load_done (load_done),
    .load_cmd  (load_cmd),
    .interrupt (interrupt)
  );

  instr_fetch u_instr_fetch (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .load_cmd      (load_cmd),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast),
    .beat          (beat)
  );

  instr_unpack u_instr_unpack (
    .ap_clk (ap_clk),
    .areset (areset),
    .beat   (beat),
    .row_wr (row_wr)
  );

  instr_table u_instr_table (
    .ap_clk (ap_clk),
    .areset (areset),
    .row_wr (row_wr),
    .pc_ctl (pc_ctl),
    .instr  (instr)
  );

endmodule

// File: logic/ctrl_pkg.sv
`include "cgra_defines.svh"

package ctrl_pkg;

  // byte offsets on the control bus
  typedef enum logic [`CSR_ADDR_W-1:0] {
    ADDR_CTRL   = 6'h00,
    ADDR_GIER   = 6'h04,
    ADDR_IER    = 6'h08,
    ADDR_ISR    = 6'h0C,
    ADDR_PTR_LO = 6'h10,
    ADDR_PTR_HI = 6'h14,
    ADDR_ROWS   = 6'h18,
    ADDR_BUSY   = 6'h1C
  } csr_addr_e;

  // load request from the register slave to the fetch stage
  typedef struct packed {
    logic                   start;
    logic [`HBM_ADDR_W-1:0] ptr;
    logic [`PC_W:0]         rows;
  } load_cmd_t;

endpackage

// File: logic/ctrl_regs.sv
`timescale 1ns/100ps
`include "cgra_defines.svh"

module ctrl_regs (
  input  logic                      ap_clk,
  input  logic                      areset,
  input  logic [`CSR_ADDR_W-1:0]    awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`CSR_DATA_W-1:0]    wdata,
  input  logic [`CSR_DATA_W/8-1:0]  wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`CSR_ADDR_W-1:0]    araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [`CSR_DATA_W-1:0]    rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  input  logic                      load_done,
  output ctrl_pkg::load_cmd_t       load_cmd,
  output logic                      interrupt
);
  import ctrl_pkg::*;

  csr_addr_e              wr_addr;
  csr_addr_e              rd_addr;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   start_wr;
  logic                   start_q;
  logic                   idle_q;
  logic                   done_q;
  logic                   gie_q;
  logic                   ier_q;
  logic                   isr_q;
  logic [`HBM_ADDR_W-1:0] ptr_q;
  logic [`PC_W:0]         rows_q;
  logic [`CSR_DATA_W-1:0] busy_q;
  logic [`CSR_DATA_W-1:0] rd_mux;

  assign wr_addr = csr_addr_e'(awaddr);
  assign rd_addr = csr_addr_e'(araddr);
  assign wr_fire = awvalid & awready;
  assign rd_fire = arvalid & arready;
  // start only taken while the kernel is idle
  assign start_wr = wr_fire && (wr_addr == ADDR_CTRL) && wdata[0] && idle_q;

  // aw and w accepted together, one response in flight at most
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~awready & ~bvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      arready <= arvalid & ~arready & ~rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  assign wready = awready;
  assign bresp  = 2'b00;
  assign rresp  = 2'b00;

  // read data mux
  always_comb begin
    rd_mux = '0;
    case (rd_addr)
      ADDR_CTRL:   rd_mux[3:0] = {done_q, idle_q, done_q, start_q};
      ADDR_GIER:   rd_mux[0] = gie_q;
      ADDR_IER:    rd_mux[0] = ier_q;
      ADDR_ISR:    rd_mux[0] = isr_q;
      ADDR_PTR_LO: rd_mux = ptr_q[`CSR_DATA_W-1:0];
      ADDR_PTR_HI: rd_mux = ptr_q[`HBM_ADDR_W-1:`CSR_DATA_W];
      ADDR_ROWS:   rd_mux[`PC_W:0] = rows_q;
      ADDR_BUSY:   rd_mux = busy_q;
      default:     rd_mux = '0;
    endcase
  end

  // captured at the read handshake
  always_ff @(posedge ap_clk) begin
    if (rd_fire) begin
      rdata <= rd_mux;
    end
  end

  // host configuration registers
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      gie_q  <= 1'b0;
      ier_q  <= 1'b0;
      ptr_q  <= '0;
      rows_q <= '0;
    end else if (wr_fire) begin
      case (wr_addr)
        ADDR_GIER: gie_q <= wdata[0];
        ADDR_IER:  ier_q <= wdata[0];
        ADDR_ROWS: rows_q <= wdata[`PC_W:0];
        ADDR_PTR_LO: begin
          for (int b = 0; b < `CSR_DATA_W/8; b++) begin
            if (wstrb[b]) ptr_q[8*b +: 8] <= wdata[8*b +: 8];
          end
        end
        ADDR_PTR_HI: begin
          for (int b = 0; b < `CSR_DATA_W/8; b++) begin
            if (wstrb[b]) ptr_q[`CSR_DATA_W + 8*b +: 8] <= wdata[8*b +: 8];
          end
        end
        default: ;
      endcase
    end
  end

  // start/done/idle handshake with the loader
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_q <= 1'b0;
      idle_q  <= 1'b1;
      done_q  <= 1'b0;
      isr_q   <= 1'b0;
      busy_q  <= '0;
    end else begin
      start_q <= start_wr;
      if (load_done) begin
        idle_q <= 1'b1;
      end else if (start_wr) begin
        idle_q <= 1'b0;
      end
      // done sticks until ctrl is read, a new done wins
      if (load_done) begin
        done_q <= 1'b1;
      end else if (rd_fire && (rd_addr == ADDR_CTRL)) begin
        done_q <= 1'b0;
      end
      // write 1 toggles, done event sets when enabled
      isr_q <= (isr_q ^ (wr_fire && (wr_addr == ADDR_ISR) && wdata[0])) | (load_done & ier_q);
      // cycles spent loading
      if (start_wr) begin
        busy_q <= '0;
      end else if (!idle_q) begin
        busy_q <= busy_q + 1'b1;
      end
    end
  end

  assign interrupt = gie_q & ier_q & isr_q;
  assign load_cmd  = '{start: start_q, ptr: ptr_q, rows: rows_q};

endmodule

// File: logic/instr_fetch.sv
`timescale 1ns/100ps
`include "cgra_defines.svh"

module instr_fetch (
  input  logic                   ap_clk,
  input  logic                   areset,
  input  ctrl_pkg::load_cmd_t    load_cmd,
  output logic                   m_axi_arvalid,
  input  logic                   m_axi_arready,
  output logic [`HBM_ADDR_W-1:0] m_axi_araddr,
  output logic [7:0]             m_axi_arlen,
  input  logic                   m_axi_rvalid,
  output logic                   m_axi_rready,
  input  logic [`PHIT_W-1:0]     m_axi_rdata,
  input  logic                   m_axi_rlast,
  output loader_pkg::phit_t      beat
);
  import loader_pkg::*;

  // 4 rows per burst, so the burst count is rows/4
  localparam int ROWS_PER_BURST = `BURST_BEATS / `ROW_BEATS;
  localparam logic [`HBM_ADDR_W-1:0] BURST_BYTES = `HBM_ADDR_W'(`BURST_BEATS * `PHIT_W / 8);

  fetch_state_e       state_q;
  logic [`PC_W:0]     bursts_left;
  logic               final_burst;
  logic               burst_end;
  logic               beat_valid_q;
  logic [`PHIT_W-1:0] beat_data_q;
  logic               beat_last_q;

  assign final_burst = (bursts_left == 1);
  assign burst_end   = (state_q == FS_DATA) && m_axi_rvalid && m_axi_rlast;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state_q     <= FS_IDLE;
      bursts_left <= '0;
    end else begin
      case (state_q)
        FS_IDLE: begin
          if (load_cmd.start) begin
            state_q     <= FS_ADDR;
            bursts_left <= load_cmd.rows >> $clog2(ROWS_PER_BURST);
          end
        end
        FS_ADDR: begin
          if (m_axi_arready) state_q <= FS_DATA;
        end
        FS_DATA: begin
          if (burst_end) begin
            bursts_left <= bursts_left - 1'b1;
            state_q     <= final_burst ? FS_IDLE : FS_ADDR;
          end
        end
        default: state_q <= FS_IDLE;
      endcase
    end
  end

  // pointer latched at start, then stepped one burst at a time
  always_ff @(posedge ap_clk) begin
    if ((state_q == FS_IDLE) && load_cmd.start) begin
      m_axi_araddr <= load_cmd.ptr;
    end else if (burst_end) begin
      m_axi_araddr <= m_axi_araddr + BURST_BYTES;
    end
  end

  assign m_axi_arvalid = (state_q == FS_ADDR);
  assign m_axi_rready  = (state_q == FS_DATA);
  assign m_axi_arlen   = 8'(`BURST_BEATS - 1);

  // beat register toward unpack
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      beat_valid_q <= 1'b0;
    end else begin
      beat_valid_q <= m_axi_rvalid & m_axi_rready;
    end
  end

  always_ff @(posedge ap_clk) begin
    beat_data_q <= m_axi_rdata;
    // last beat of the final burst ends the load
    beat_last_q <= m_axi_rlast & final_burst;
  end

  assign beat = '{valid: beat_valid_q, data: beat_data_q, last: beat_last_q};

endmodule

// File: logic/instr_table.sv
`timescale 1ns/100ps
`include "cgra_defines.svh"

module instr_table (
  input  logic                                 ap_clk,
  input  logic                                 areset,
  input  loader_pkg::row_wr_t                  row_wr,
  input  loader_pkg::pc_ctl_t [`NUM_COL-1:0]   pc_ctl,
  output logic [`NUM_COL*`INSTR_W-1:0]         instr
);

  for (genvar c = 0; c < `NUM_COL; c++) begin : g_col
    logic [`INSTR_W-1:0] mem [`TBL_DEPTH];
    logic [`PC_W-1:0]    pc_q;
    logic [`INSTR_W-1:0] instr_q;

    // all columns written from the same row
    always_ff @(posedge ap_clk) begin
      if (row_wr.valid) begin
        mem[row_wr.idx] <= row_wr.data[c*`INSTR_W +: `INSTR_W];
      end
    end

    // load beats incr, pc wraps at table depth
    always_ff @(posedge ap_clk) begin
      if (areset) begin
        pc_q    <= '0;
        instr_q <= '0;
      end else begin
        if (pc_ctl[c].clken) begin
          if (pc_ctl[c].load) begin
            pc_q <= pc_ctl[c].value;
          end else if (pc_ctl[c].incr) begin
            pc_q <= pc_q + 1'b1;
          end
        end
        // instruction one cycle behind the pc
        instr_q <= mem[pc_q];
      end
    end

    assign instr[c*`INSTR_W +: `INSTR_W] = instr_q;
  end

endmodule

// File: logic/instr_unpack.sv
`timescale 1ns/100ps
`include "cgra_defines.svh"

module instr_unpack (
  input  logic                ap_clk,
  input  logic                areset,
  input  loader_pkg::phit_t   beat,
  output loader_pkg::row_wr_t row_wr
);

  logic [`PHIT_W-1:0]           even_q;
  // next beat completes a row
  logic                         odd_q;
  // next even beat opens a new load
  logic                         fresh_q;
  logic [`PC_W-1:0]             idx_q;
  logic                         row_valid_q;
  logic [`PC_W-1:0]             row_idx_q;
  logic [`NUM_COL*`INSTR_W-1:0] row_data_q;
  logic                         row_last_q;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      odd_q       <= 1'b0;
      fresh_q     <= 1'b1;
      idx_q       <= '0;
      row_valid_q <= 1'b0;
    end else begin
      row_valid_q <= beat.valid & odd_q;
      if (beat.valid) begin
        odd_q <= ~odd_q;
        if (!odd_q) begin
          if (fresh_q) idx_q <= '0;
          fresh_q <= 1'b0;
        end else begin
          idx_q <= idx_q + 1'b1;
          if (beat.last) fresh_q <= 1'b1;
        end
      end
    end
  end

  // even phit holds columns 0/1, odd phit columns 2/3
  always_ff @(posedge ap_clk) begin
    if (beat.valid && !odd_q) begin
      even_q <= beat.data;
    end
    if (beat.valid && odd_q) begin
      row_data_q <= {beat.data, even_q};
      row_idx_q  <= idx_q;
      row_last_q <= beat.last;
    end
  end

  assign row_wr = '{valid: row_valid_q, idx: row_idx_q, data: row_data_q, last: row_last_q};

endmodule

// File: logic/loader_pkg.sv
`include "cgra_defines.svh"

package loader_pkg;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_ADDR,
    FS_DATA
  } fetch_state_e;

  // one read beat, last marks the final beat of the whole load
  typedef struct packed {
    logic               valid;
    logic [`PHIT_W-1:0] data;
    logic               last;
  } phit_t;

  // one row written to all columns at once, column c at bits 32c upward
  typedef struct packed {
    logic                         valid;
    logic [`PC_W-1:0]             idx;
    logic [`NUM_COL*`INSTR_W-1:0] data;
    logic                         last;
  } row_wr_t;

  // per-column program counter control from the array
  typedef struct packed {
    logic             clken;
    logic             load;
    logic             incr;
    logic [`PC_W-1:0] value;
  } pc_ctl_t;

endpackage
